//--- hdl/pecPkg.sv
//====================================================================
// Shared sizes and types of the convolution row engine
// Element, partial-sum and channel-index typedefs
// Activation vector, weight block and per-tap result types
// Controller state encoding
//====================================================================
`default_nettype none

package pecPkg;

    localparam int DataWidth    = 8;   // One weight or activation element
    localparam int ChannelDepth = 4;   // Channels per vector and per tap
    localparam int KernelSize   = 3;   // Taps, also the window length

    // Product width, channel growth and two guard bits
    localparam int PsumWidth = 2 * DataWidth + $clog2(ChannelDepth) + 2;

    typedef logic signed [DataWidth-1:0]     dataT;
    typedef logic signed [PsumWidth-1:0]     psumT;
    typedef logic [$clog2(ChannelDepth)-1:0] chanIdxT;

    typedef dataT [ChannelDepth-1:0]                  actVecT;   // One activation vector
    typedef dataT [KernelSize-1:0][ChannelDepth-1:0]  weiBlkT;   // Tap-major weight block
    typedef psumT [KernelSize-1:0]                    tapPsumT;  // One dot product per tap

    typedef enum logic [1:0] {
        LoadWei,
        WaitAct,
        Compute,
        Drain
    } pecStateT;

endpackage

`default_nettype wire

//--- hdl/pecMacIf.sv
//====================================================================
// Link between controller, dot-product engine and partial-sum chain
// Load and start strobes, done strobe and per-tap results
//====================================================================
`timescale 1ns/10ps
`default_nettype none

interface pecMacIf;

    logic             weiLoad;  // Capture weight block
    logic             start;    // Capture activation and run
    logic             done;     // Dot products complete
    pecPkg::tapPsumT  dot;      // Held from done onward

    modport ctrl   (output weiLoad, output start, input done);
    modport engine (input weiLoad, input start, output done, output dot);
    modport accum  (input done, input dot);

endinterface

`default_nettype wire

//--- hdl/pecCtrl.sv
//====================================================================
// Sequencer of the convolution row engine
// FSM over weight load, activation accept, compute and drain
// Weight and activation ready, engine load and start strobes
//====================================================================
`timescale 1ns/10ps
`default_nettype none

module pecCtrl (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  weiValid,
    output logic  weiReady,
    input  logic  actValid,
    output logic  actReady,
    input  logic  lstActBlk,
    input  logic  outBusy,
    pecMacIf.ctrl mac
);

    pecPkg::pecStateT state;
    pecPkg::pecStateT stateNxt;
    logic             weiXfer;
    logic             actXfer;
    logic             lstBlkReg;   // Block end flag of the current activation

    //====================================================================
    // Handshakes and strobes
    //====================================================================
    assign weiReady = (state == pecPkg::LoadWei);
    assign actReady = (state == pecPkg::WaitAct) && !outBusy;  // One sum waiting at most

    assign weiXfer = weiValid && weiReady;
    assign actXfer = actValid && actReady;

    assign mac.weiLoad = weiXfer;
    assign mac.start   = actXfer;   // Engine captures act on the transfer edge

    //====================================================================
    // State machine
    //====================================================================
    always_comb begin
        stateNxt = state;
        case (state)
            pecPkg::LoadWei: if (weiXfer) stateNxt = pecPkg::WaitAct;
            pecPkg::WaitAct: if (actXfer) stateNxt = pecPkg::Compute;
            pecPkg::Compute: if (mac.done) stateNxt = pecPkg::Drain;
            pecPkg::Drain: begin
                // Last activation of the block goes back for new weights
                stateNxt = lstBlkReg ? pecPkg::LoadWei : pecPkg::WaitAct;
            end
            default: stateNxt = pecPkg::LoadWei;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= pecPkg::LoadWei;
        end else begin
            state <= stateNxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lstBlkReg <= 1'b0;
        end else if (actXfer) begin
            lstBlkReg <= lstActBlk;
        end
    end

endmodule

`default_nettype wire

//--- hdl/dotEngine.sv
//====================================================================
// Dot-product engine of the convolution row
// Weight block and activation registers
// Serial channel walk with one accumulator per tap
//====================================================================
`timescale 1ns/10ps
`default_nettype none

module dotEngine (
    input  logic           clk,
    input  logic           rst_n,
    input  pecPkg::weiBlkT wei,
    input  pecPkg::actVecT act,
    pecMacIf.engine        mac
);

    pecPkg::weiBlkT  weiReg;
    pecPkg::actVecT  actReg;
    pecPkg::chanIdxT chanCnt;    // Channel being multiplied
    logic            busy;
    logic            lastChan;
    pecPkg::tapPsumT prod;       // Current channel product per tap
    pecPkg::tapPsumT acc;

    //====================================================================
    // Operand capture
    //====================================================================
    always_ff @(posedge clk) begin
        if (mac.weiLoad) begin
            weiReg <= wei;
        end
        if (mac.start) begin
            actReg <= act;
        end
    end

    //====================================================================
    // Channel stepping
    //====================================================================
    assign lastChan = (chanCnt == pecPkg::chanIdxT'(pecPkg::ChannelDepth - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            chanCnt  <= '0;
            mac.done <= 1'b0;
        end else begin
            mac.done <= busy && lastChan;   // Rises with the final accumulate
            if (mac.start) begin
                busy    <= 1'b1;
                chanCnt <= '0;
            end else if (busy) begin
                if (lastChan) begin
                    busy    <= 1'b0;
                    chanCnt <= '0;
                end else begin
                    chanCnt <= chanCnt + 1'b1;
                end
            end
        end
    end

    // Same activation element against every tap
    always_comb begin
        for (int t = 0; t < pecPkg::KernelSize; t++) begin
            prod[t] = actReg[chanCnt] * weiReg[t][chanCnt];   // Signed, widened to psum
        end
    end

    always_ff @(posedge clk) begin
        if (mac.start) begin
            acc <= '0;
        end else if (busy) begin
            for (int t = 0; t < pecPkg::KernelSize; t++) begin
                acc[t] <= acc[t] + prod[t];
            end
        end
    end

    assign mac.dot = acc;   // Stable until the next start

endmodule

`default_nettype wire

//--- hdl/rowAccum.sv
//====================================================================
// Window partial-sum chain of the convolution row
// Row flag capture and row position count
// Output register with valid/ready hold
//====================================================================
`timescale 1ns/10ps
`default_nettype none

module rowAccum (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          actValid,
    input  logic          actReady,
    input  logic          frtActRow,
    input  logic          lstActRow,
    output logic          psumValid,
    input  logic          psumReady,
    output pecPkg::psumT  psum,
    output logic          outBusy,
    pecMacIf.accum        mac
);

    localparam int CntW = $clog2(pecPkg::KernelSize + 1);

    logic            actXfer;
    logic            frtReg;
    logic            lstReg;
    logic [CntW-1:0] rowPos;      // Activations seen in this row, saturating
    logic [CntW-1:0] rowPosNxt;
    logic            winDone;
    pecPkg::psumT    chain [pecPkg::KernelSize-1];
    pecPkg::psumT    winSum;

    assign actXfer = actValid && actReady;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frtReg <= 1'b0;
            lstReg <= 1'b0;
        end else if (actXfer) begin
            frtReg <= frtActRow;
            lstReg <= lstActRow;
        end
    end

    //====================================================================
    // Row position
    //====================================================================
    always_comb begin
        if (frtReg) begin
            rowPosNxt = CntW'(1);                      // First of a new row
        end else if (rowPos == CntW'(pecPkg::KernelSize)) begin
            rowPosNxt = rowPos;
        end else begin
            rowPosNxt = rowPos + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rowPos <= '0;
        end else if (mac.done) begin
            rowPos <= lstReg ? '0 : rowPosNxt;
        end
    end

    assign winDone = mac.done && (rowPosNxt == CntW'(pecPkg::KernelSize));

    //====================================================================
    // Chain and output
    //====================================================================
    always_ff @(posedge clk) begin
        if (mac.done) begin
            chain[0] <= mac.dot[0];                    // Opens a new window
            for (int j = 1; j < pecPkg::KernelSize - 1; j++) begin
                chain[j] <= chain[j-1] + mac.dot[j];
            end
        end
    end

    assign winSum = chain[pecPkg::KernelSize-2] + mac.dot[pecPkg::KernelSize-1];

    always_ff @(posedge clk) begin
        if (winDone) begin
            psum <= winSum;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psumValid <= 1'b0;
        end else if (winDone) begin
            psumValid <= 1'b1;
        end else if (psumReady) begin
            psumValid <= 1'b0;                         // Taken by the sink
        end
    end

    assign outBusy = psumValid;

endmodule

`default_nettype wire

//--- hdl/pecTop.sv
//====================================================================
// Convolution row engine top level
// Controller, dot-product engine and partial-sum chain
// joined by one engine interface
//====================================================================
`timescale 1ns/10ps
`default_nettype none

module pecTop (
    input  logic           clk,
    input  logic           rst_n,
    // Weight block
    input  logic           weiValid,
    output logic           weiReady,
    input  pecPkg::weiBlkT wei,
    // Activation stream
    input  logic           actValid,
    output logic           actReady,
    input  pecPkg::actVecT act,
    input  logic           frtActRow,
    input  logic           lstActRow,
    input  logic           lstActBlk,
    // Window partial sums
    output logic           psumValid,
    input  logic           psumReady,
    output pecPkg::psumT   psum
);

    logic outBusy;   // Sum waiting at the output

    pecMacIf macIf ();

    pecCtrl i_pecCtrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .weiValid  (weiValid),
        .weiReady  (weiReady),
        .actValid  (actValid),
        .actReady  (actReady),
        .lstActBlk (lstActBlk),
        .outBusy   (outBusy),
        .mac       (macIf.ctrl)
    );

    dotEngine i_dotEngine (
        .clk   (clk),
        .rst_n (rst_n),
        .wei   (wei),
        .act   (act),
        .mac   (macIf.engine)
    );

    rowAccum i_rowAccum (
        .clk       (clk),
        .rst_n     (rst_n),
        .actValid  (actValid),
        .actReady  (actReady),
        .frtActRow (frtActRow),
        .lstActRow (lstActRow),
        .psumValid (psumValid),
        .psumReady (psumReady),
        .psum      (psum),
        .outBusy   (outBusy),
        .mac       (macIf.accum)
    );

endmodule

`default_nettype wire

//--- tb/pecTb.sv
//====================================================================
// Testbench of the convolution row engine
// Clock, reset, random weight and activation blocks
// Window reference model, output compare process and watchdog
//====================================================================
`timescale 1ns/10ps
`default_nettype none

module pecTb;

    localparam int NumBlk = 2;
    localparam int NumRow = 2;
    localparam int MaxLen = 6;

    logic             clk;
    logic             rst_n;
    logic             weiValid;
    logic             weiReady;
    pecPkg::weiBlkT   wei;
    logic             actValid;
    logic             actReady;
    pecPkg::actVecT   act;
    logic             frtActRow;
    logic             lstActRow;
    logic             lstActBlk;
    logic             psumValid;
    logic             psumReady;
    pecPkg::psumT     psum;

    int               seed = 32'h0ad9c463;
    logic             stimReady = 1'b0;
    int               totalActs = 0;
    pecPkg::weiBlkT   weiStore [NumBlk];
    pecPkg::actVecT   actStore [NumBlk][NumRow][MaxLen];
    int               rowLen   [NumBlk][NumRow];
    pecPkg::psumT     expQ [$];       // Expected sums in output order
    logic             holdValid = 1'b0;
    pecPkg::psumT     heldPsum;

    pecTop i_pecTop (
        .clk       (clk),
        .rst_n     (rst_n),
        .weiValid  (weiValid),
        .weiReady  (weiReady),
        .wei       (wei),
        .actValid  (actValid),
        .actReady  (actReady),
        .act       (act),
        .frtActRow (frtActRow),
        .lstActRow (lstActRow),
        .lstActBlk (lstActBlk),
        .psumValid (psumValid),
        .psumReady (psumReady),
        .psum      (psum)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //====================================================================
    // Reference model and checks
    //====================================================================
    // Sum over taps of dot(act[k+t], tap t)
    function automatic pecPkg::psumT windowSum(input int b, input int r, input int k);
        int          acc;
        pecPkg::dataT x;
        pecPkg::dataT y;
        acc = 0;
        for (int t = 0; t < pecPkg::KernelSize; t++) begin
            for (int c = 0; c < pecPkg::ChannelDepth; c++) begin
                x = actStore[b][r][k+t][c];
                y = weiStore[b][t][c];
                acc += int'(x) * int'(y);
            end
        end
        return pecPkg::psumT'(acc);
    endfunction

    task automatic failRun();
        $display("sim failed");
        $fatal(1, "Run stopped on error");
    endtask

    task automatic checkPsum(input string name, input pecPkg::psumT exp, input pecPkg::psumT got);
        if (exp !== got) begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, got);
            failRun();
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic got);
        if (exp !== got) begin
            $display("ERR %0t %s expected %0b actual %0b", $time, name, exp, got);
            failRun();
        end
    endtask

    // Output side sampled at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (psumValid) begin
                checkBit("actReady", 1'b0, actReady);  // No accept while a sum waits
            end
            if (holdValid && psumValid) begin
                checkPsum("psum", heldPsum, psum);     // Held while waiting
            end
            if (psumValid && psumReady) begin
                holdValid = 1'b0;
                if (expQ.size() == 0) begin
                    $display("Output delivered a partial sum that was not expected");
                    failRun();
                end else begin
                    checkPsum("psum", expQ.pop_front(), psum);
                end
            end else begin
                holdValid = psumValid;
                heldPsum  = psum;
            end
        end
    end

    always @(posedge clk) begin
        psumReady <= ({$random(seed)} % 3) != 0;      // Withheld about a third of cycles
    end

    initial begin
        wait (stimReady);
        repeat (200 * totalActs + 200) @(posedge clk);
        $display("Watchdog expired because the partial-sum output stalled");
        failRun();
    end

    //====================================================================
    // Stimulus
    //====================================================================
    task automatic sendWei(input pecPkg::weiBlkT w);
        @(posedge clk);
        weiValid <= 1'b1;
        wei      <= w;
        do @(negedge clk); while (!weiReady);
        @(posedge clk);                                // Transfer edge
        weiValid <= 1'b0;
    endtask

    task automatic sendAct(input pecPkg::actVecT v, input logic frt, input logic lst,
                           input logic blkEnd);
        @(posedge clk);
        actValid  <= 1'b1;
        act       <= v;
        frtActRow <= frt;
        lstActRow <= lst;
        lstActBlk <= blkEnd;
        do @(negedge clk); while (!actReady);
        @(posedge clk);
        actValid  <= 1'b0;
    endtask

    // Called on the transfer edge of a window-completing activation
    task automatic checkLatency();
        repeat (pecPkg::ChannelDepth + 1) @(negedge clk);
        checkBit("psumValid", 1'b0, psumValid);
        @(negedge clk);
        checkBit("psumValid", 1'b1, psumValid);
    endtask

    initial begin : driver
        logic blkEnd;
        rst_n     = 1'b0;
        weiValid  = 1'b0;
        wei       = '0;
        actValid  = 1'b0;
        act       = '0;
        frtActRow = 1'b0;
        lstActRow = 1'b0;
        lstActBlk = 1'b0;
        psumReady = 1'b0;

        // All random data drawn before the clock runs
        for (int b = 0; b < NumBlk; b++) begin
            for (int t = 0; t < pecPkg::KernelSize; t++) begin
                for (int c = 0; c < pecPkg::ChannelDepth; c++) begin
                    weiStore[b][t][c] = pecPkg::dataT'($random(seed));
                end
            end
            for (int r = 0; r < NumRow; r++) begin
                rowLen[b][r] = 3 + int'({$random(seed)} % 4);
                totalActs   += rowLen[b][r];
                for (int i = 0; i < rowLen[b][r]; i++) begin
                    for (int c = 0; c < pecPkg::ChannelDepth; c++) begin
                        actStore[b][r][i][c] = pecPkg::dataT'($random(seed));
                    end
                end
                for (int k = 0; k <= rowLen[b][r] - pecPkg::KernelSize; k++) begin
                    expQ.push_back(windowSum(b, r, k));
                end
            end
        end
        stimReady = 1'b1;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checkBit("psumValid", 1'b0, psumValid);
        checkBit("actReady", 1'b0, actReady);
        checkBit("weiReady", 1'b1, weiReady);

        for (int b = 0; b < NumBlk; b++) begin
            sendWei(weiStore[b]);                      // Waits for the return to loading
            for (int r = 0; r < NumRow; r++) begin
                for (int i = 0; i < rowLen[b][r]; i++) begin
                    blkEnd = (r == NumRow - 1) && (i == rowLen[b][r] - 1);
                    sendAct(actStore[b][r][i], i == 0, i == rowLen[b][r] - 1, blkEnd);
                    if (i >= pecPkg::KernelSize - 1) begin
                        checkLatency();
                    end
                end
            end
        end

        while (expQ.size() != 0) @(negedge clk);
        repeat (2 * pecPkg::ChannelDepth) @(negedge clk);
        checkBit("psumValid", 1'b0, psumValid);      // No surplus sums
        checkBit("weiReady", 1'b1, weiReady);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- pecTop.f
hdl/pecPkg.sv
hdl/pecMacIf.sv
hdl/pecCtrl.sv
hdl/dotEngine.sv
hdl/rowAccum.sv
hdl/pecTop.sv
tb/pecTb.sv

//--- Makefile
TOOL     = verilator
TOP      = pecTb
FILELIST = pecTop.f
FLAGS    = --binary --timing -sv
LINTFLAGS = --lint-only --timing -sv
BUILD    = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# Simulator exit status carries pass or fail
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
